/* Makefile */
# Verilator build and run for the correlator core testbench.

SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := xc_tb
FILELIST  := xc_core.f
BUILD_DIR := obj_dir
PASS_MSG  := All checks passed

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -E '\.s?v$$' $(FILELIST))
HEADERS := $(wildcard design/*.svh verification/*.svh)

.PHONY: all run clean

all: $(BIN)

# The binary is rebuilt only when a source, a header or the file list changes.
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run fails unless the pass message shows up on a line of its own.
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* design/xc_core.sv */
`timescale 1ns/1ps
`include "xc_defs.svh"

// Top of the correlator core.
// A sampler feeds one coincidence counter per line pair.
// After each frame the readout sends the pair totals out as a word stream.
// The sample tick is exported as smpclk so that a driver can pace its lines.
module xc_core (
    input  logic              sysclk,
    input  logic              rst_n,
    input  logic              enable,
    input  xc_pkg::lines_t    line_in,
    output logic              smpclk,
    output xc_pkg::count_t    mux_out,
    output xc_pkg::pair_idx_t word_index,
    output logic              word_strobe
);

    // Current sample of all lines, held between ticks.
    xc_pkg::lines_t samples;

    // Last sample of the frame, coincident with smpclk.
    logic frame_end;

    // All pair totals, pair 0 in the lowest word.
    logic [`XC_NUM_PAIRS*`XC_RESOLUTION-1:0] results;

    // The sample strobe leaves the core directly as smpclk.
    xc_sampler u_sampler (
        .sysclk        (sysclk),
        .rst_n         (rst_n),
        .enable        (enable),
        .line_in       (line_in),
        .samples       (samples),
        .sample_strobe (smpclk),
        .frame_end     (frame_end)
    );

    // One counter per pair.
    // The line numbers of each pair come from the package mapping.
    // The testbench model walks the pairs in the same order.
    for (genvar p = 0; p < `XC_NUM_PAIRS; p++) begin : g_pair
        xc_pair_counter #(
            .LINE_A (xc_pkg::pair_line_a(p)),
            .LINE_B (xc_pkg::pair_line_b(p))
        ) u_pair_counter (
            .sysclk        (sysclk),
            .rst_n         (rst_n),
            .samples       (samples),
            .sample_strobe (smpclk),
            .frame_end     (frame_end),
            .result        (results[p*`XC_RESOLUTION +: `XC_RESOLUTION])
        );
    end

    // Word stream out of the core.
    xc_readout u_readout (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .frame_end   (frame_end),
        .results     (results),
        .mux_out     (mux_out),
        .word_index  (word_index),
        .word_strobe (word_strobe)
    );

endmodule

/* design/xc_defs.svh */
`ifndef XC_DEFS_SVH
`define XC_DEFS_SVH

// Sizes of the correlator core.
// All RTL files and the testbench take their dimensions from here.

// Number of one-bit input lines.
// This is the width of line_in and of one sample.
`define XC_NUM_LINES 4

// Number of line pairs (i <= j) for four lines.
// This covers four auto pairs and six cross pairs.
// It is also the number of words sent per frame.
`define XC_NUM_PAIRS 10

// Width of one coincidence count word.
`define XC_RESOLUTION 16

// Number of sysclk cycles between two samples while enabled.
// Keep this at 4 or more so the two-flop synchronizer settles between ticks.
`define XC_SAMPLE_DIV 8

// Number of samples that make up one correlation frame.
// A frame must last longer than one readout burst.
`define XC_FRAME_SAMPLES 64

`endif

/* design/xc_pair_counter.sv */
`timescale 1ns/1ps
`include "xc_defs.svh"

// Coincidence counter for one line pair.
// For an auto pair LINE_A equals LINE_B and this counts the ones of that line.
// The running total restarts every frame.
// The finished total is held in result until the next frame ends.
module xc_pair_counter #(
    parameter int LINE_A = 0,
    parameter int LINE_B = 0
) (
    input  logic           sysclk,
    input  logic           rst_n,
    input  xc_pkg::lines_t samples,
    input  logic           sample_strobe,
    input  logic           frame_end,
    output xc_pkg::count_t result
);

    // Largest count the accumulator can hold.
    localparam xc_pkg::count_t COUNT_MAX = '1;

    // Running count for the current frame.
    xc_pkg::count_t acc;

    // Count including the sample presented in this cycle.
    xc_pkg::count_t acc_next;

    // Both lines of the pair are high in the current sample.
    logic hit;

    assign hit = samples[LINE_A] & samples[LINE_B];

    // Add one per coincident sample, and stick at the top instead of wrapping.
    always_comb begin
        acc_next = acc;
        if (sample_strobe && hit && (acc != COUNT_MAX)) begin
            acc_next = acc + 1'b1;
        end
    end

    // frame_end comes with the strobe of the last sample.
    // So the total moved to result must be acc_next and not acc.
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            acc    <= '0;
            result <= '0;
        end else if (frame_end) begin
            result <= acc_next;
            acc    <= '0;
        end else begin
            acc <= acc_next;
        end
    end

    // A frame total at full scale may have been clipped.
    // Flag it so a too short count word does not pass silently.
    assert property (@(posedge sysclk) disable iff (!rst_n)
        frame_end |-> (acc_next != COUNT_MAX))
    else
        $error("xc_pair_counter(%0d,%0d): count saturated in frame", LINE_A, LINE_B);

endmodule

/* design/xc_pkg.sv */
`include "xc_defs.svh"

package xc_pkg;

    // One sample of all input lines, line 0 in bit 0.
    typedef logic [`XC_NUM_LINES-1:0] lines_t;

    // One coincidence count.
    typedef logic [`XC_RESOLUTION-1:0] count_t;

    // Pair number, 0 to XC_NUM_PAIRS-1.
    typedef logic [$clog2(`XC_NUM_PAIRS)-1:0] pair_idx_t;

    // States of the readout FSM.
    typedef enum logic {
        IDLE,
        SEND
    } readout_state_t;

    // Pairs are numbered row by row over the upper triangle.
    // The order is (0,0) (0,1) (0,2) (0,3) (1,1) (1,2) (1,3) (2,2) (2,3) (3,3).
    // Both functions walk the same triangle and return one coordinate each.
    function automatic int pair_line_a(input int pair);
        int n;
        int a;
        n = 0;
        a = 0;
        for (int i = 0; i < `XC_NUM_LINES; i++) begin
            for (int j = i; j < `XC_NUM_LINES; j++) begin
                if (n == pair) begin
                    a = i;
                end
                n++;
            end
        end
        return a;
    endfunction

    // Second line of a pair, in the same order as pair_line_a.
    function automatic int pair_line_b(input int pair);
        int n;
        int b;
        n = 0;
        b = 0;
        for (int i = 0; i < `XC_NUM_LINES; i++) begin
            for (int j = i; j < `XC_NUM_LINES; j++) begin
                if (n == pair) begin
                    b = j;
                end
                n++;
            end
        end
        return b;
    endfunction

endpackage

/* design/xc_readout.sv */
`timescale 1ns/1ps
`include "xc_defs.svh"

// Readout of the latched pair totals.
// After each frame the ten totals go out one word per cycle on mux_out.
// word_index names the pair and word_strobe marks every valid word.
// There is no back-pressure, so the burst always runs to the end.
module xc_readout (
    input  logic                                      sysclk,
    input  logic                                      rst_n,
    input  logic                                      frame_end,
    input  logic [`XC_NUM_PAIRS*`XC_RESOLUTION-1:0]   results,
    output xc_pkg::count_t                            mux_out,
    output xc_pkg::pair_idx_t                         word_index,
    output logic                                      word_strobe
);

    // Index of the last pair in the burst.
    localparam xc_pkg::pair_idx_t LAST_IDX = xc_pkg::pair_idx_t'(`XC_NUM_PAIRS - 1);

    xc_pkg::readout_state_t state;

    // Pair currently presented on mux_out.
    xc_pkg::pair_idx_t idx;

    // The word on the bus in this cycle is the last of the burst.
    logic last_word;

    assign last_word = (idx == LAST_IDX);

    // The FSM leaves IDLE on the cycle after frame_end.
    // By then every pair counter has moved its total into its result register.
    // In SEND the index steps once per cycle and the FSM drops back after pair 9.
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= xc_pkg::IDLE;
            idx   <= '0;
        end else begin
            case (state)
                xc_pkg::IDLE: begin
                    if (frame_end) begin
                        state <= xc_pkg::SEND;
                        idx   <= '0;
                    end
                end
                xc_pkg::SEND: begin
                    if (last_word) begin
                        state <= xc_pkg::IDLE;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                default: begin
                    state <= xc_pkg::IDLE;
                    idx   <= '0;
                end
            endcase
        end
    end

    // Outputs decode straight from the state and index registers.
    // The first word therefore appears one cycle after frame_end.
    // Between bursts the index rests at 0 and the data bus is held at 0.
    assign word_strobe = (state == xc_pkg::SEND);
    assign word_index  = idx;

    // Pair 0 sits in the lowest word of the flat result bus.
    always_comb begin
        if (word_strobe) begin
            mux_out = results[int'(idx) * `XC_RESOLUTION +: `XC_RESOLUTION];
        end else begin
            mux_out = '0;
        end
    end

    // A new frame must not end while the previous one is still being sent.
    // The totals would be replaced under the running burst.
    // The frame length is chosen so this never happens.
    assert property (@(posedge sysclk) disable iff (!rst_n)
        frame_end |-> (state == xc_pkg::IDLE))
    else
        $error("xc_readout: frame_end arrived during readout burst");

endmodule

/* design/xc_sampler.sv */
`timescale 1ns/1ps
`include "xc_defs.svh"

// Sampling front end of the correlator.
// The input lines are asynchronous to sysclk and pass two flops first.
// A divider turns sysclk into one sample tick every XC_SAMPLE_DIV cycles,
// but only while enable is high.
// A frame counter marks the last sample of each frame.
module xc_sampler (
    input  logic           sysclk,
    input  logic           rst_n,
    input  logic           enable,
    input  xc_pkg::lines_t line_in,
    output xc_pkg::lines_t samples,
    output logic           sample_strobe,
    output logic           frame_end
);

    localparam int DIV_W   = $clog2(`XC_SAMPLE_DIV);
    localparam int FRAME_W = $clog2(`XC_FRAME_SAMPLES);

    // Divider position within one sample period.
    logic [DIV_W-1:0] div_cnt;

    // Number of samples already taken in the current frame.
    logic [FRAME_W-1:0] frame_cnt;

    // Synchronizer stages for the asynchronous lines.
    xc_pkg::lines_t sync_q1;
    xc_pkg::lines_t sync_q2;

    // High in the cycle where the divider wraps.
    logic tick;

    // High when the sample taken on this tick is the last of the frame.
    logic last_sample;

    assign tick        = enable && (div_cnt == DIV_W'(`XC_SAMPLE_DIV - 1));
    assign last_sample = (frame_cnt == FRAME_W'(`XC_FRAME_SAMPLES - 1));

    // The divider only moves while enabled.
    // Dropping enable freezes it mid-period, and the period resumes where it stopped.
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (enable) begin
            if (tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Strobe and frame marker are registered so that they line up with
    // the captured sample.
    // The frame counter advances once per tick and so also holds while disabled.
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            sample_strobe <= 1'b0;
            frame_end     <= 1'b0;
            frame_cnt     <= '0;
        end else begin
            sample_strobe <= tick;
            frame_end     <= tick && last_sample;
            if (tick) begin
                if (last_sample) begin
                    frame_cnt <= '0;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

    // Two flops bring the lines into the sysclk domain.
    // The capture register takes the second stage on the tick.
    // The counted value is therefore the line as it stood three edges before
    // the strobe is seen.
    always_ff @(posedge sysclk) begin
        sync_q1 <= line_in;
        sync_q2 <= sync_q1;
        if (tick) begin
            samples <= sync_q2;
        end
    end

    // The frame marker must always ride on a sample strobe.
    // The pair counters rely on this to include the last sample in the total.
    assert property (@(posedge sysclk) disable iff (!rst_n)
        frame_end |-> sample_strobe)
    else
        $error("xc_sampler: frame_end without sample_strobe");

endmodule

/* verification/xc_ref_model.svh */
`ifndef XC_REF_MODEL_SVH
`define XC_REF_MODEL_SVH

// Reference model of the pair counters.
// It works on one whole frame of recorded line samples at a time.
// Line 0 sits in bit 0 of each sample, as on line_in.

// Number of samples in the frame where line a and line b are both high.
// With a equal to b this is simply the number of ones on that line.
function automatic int coincidences(
    input xc_pkg::lines_t frame [`XC_FRAME_SAMPLES],
    input int             a,
    input int             b
);
    int hits;
    hits = 0;
    for (int s = 0; s < `XC_FRAME_SAMPLES; s++) begin
        if (frame[s][a] && frame[s][b]) begin
            hits++;
        end
    end
    return hits;
endfunction

// Expected words of one readout burst.
// Pairs are numbered row by row over the upper triangle (i <= j),
// so the order is (0,0) (0,1) (0,2) (0,3) (1,1) (1,2) ... (3,3).
// A frame of 64 samples never reaches the top of a 16-bit count,
// so no clipping is modelled here.
function automatic void ref_pair_counts(
    input  xc_pkg::lines_t frame  [`XC_FRAME_SAMPLES],
    output xc_pkg::count_t counts [`XC_NUM_PAIRS]
);
    int pair;
    pair = 0;
    for (int a = 0; a < `XC_NUM_LINES; a++) begin
        for (int b = a; b < `XC_NUM_LINES; b++) begin
            counts[pair] = xc_pkg::count_t'(coincidences(frame, a, b));
            pair++;
        end
    end
endfunction

`endif

/* verification/xc_tb.sv */
`timescale 1ns/1ps
`include "xc_defs.svh"

// Testbench of the correlator core.
// The main process resets the DUT and drives frames of line values.
// A separate process follows the word stream and compares it with the model.
module xc_tb;

    `include "xc_ref_model.svh"

    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 8;
    localparam int PAUSE_CYCLES = 400;
    localparam int PAUSE_AFTER  = 20;
    localparam int TOTAL_FRAMES = 5;

    // The run takes about 3,000 cycles (five frames of 512, the pause and reset).
    // The limit leaves roughly a factor of two on top of that.
    localparam int TIMEOUT_CYCLES = 6000;

    logic              sysclk;
    logic              rst_n;
    logic              enable;
    xc_pkg::lines_t    line_in;
    logic              smpclk;
    xc_pkg::count_t    mux_out;
    xc_pkg::pair_idx_t word_index;
    logic              word_strobe;

    // Line values that the DUT counted in the current frame.
    xc_pkg::lines_t frame_samples [`XC_FRAME_SAMPLES];

    int checks         = 0;
    int errors         = 0;
    int errors_mark    = 0;
    int framing_errors = 0;
    int frames_checked = 0;
    int cycle_count    = 0;

    xc_core UUT (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .enable      (enable),
        .line_in     (line_in),
        .smpclk      (smpclk),
        .mux_out     (mux_out),
        .word_index  (word_index),
        .word_strobe (word_strobe)
    );

    initial begin : clock_gen
        sysclk = 1'b0;
        forever begin
            #5 sysclk = ~sysclk;
        end
    end

    // Ends a hung run once the cycle budget is used up.
    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge sysclk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    // Prints one line for a finished test, with the errors found since the last one.
    task automatic finish_test(input string name);
        int test_errors;
        test_errors = errors - errors_mark;
        errors_mark = errors;
        $display("Test %s: %0d errors", name, test_errors);
    endtask

    // Outside any frame activity all outputs must rest at zero.
    task automatic check_idle_outputs();
        checks++;
        assert (!smpclk && !word_strobe && mux_out == '0 && word_index == '0) else begin
            errors++;
            $display("FAILED at time %0t: outputs not idle, smpclk=%0b strobe=%0b data=%0d idx=%0d",
                     $time, smpclk, word_strobe, mux_out, word_index);
        end
    endtask

    // Value for the next sample, either all lines high or random.
    function automatic xc_pkg::lines_t next_lines(input bit random_lines);
        if (random_lines) begin
            return xc_pkg::lines_t'($urandom);
        end else begin
            return '1;
        end
    endfunction

    // Drops enable for the pause; nothing may come out of the DUT meanwhile.
    task automatic hold_paused();
        enable <= 1'b0;
        repeat (PAUSE_CYCLES) begin
            @(posedge sysclk);
            checks++;
            assert (!smpclk && !word_strobe) else begin
                errors++;
                $display("Activity during the pause at time %0t: smpclk=%0b word_strobe=%0b",
                         $time, smpclk, word_strobe);
            end
        end
        enable <= 1'b1;
    endtask

    // One frame of 64 samples.
    // A new value goes out on the edge that sees smpclk, so it is stable
    // long before the next capture, and the value held up to a pulse is
    // the one that pulse counted.
    task automatic run_frame(input bit random_lines, input int pause_after);
        xc_pkg::lines_t held;
        held = next_lines(random_lines);
        line_in <= held;
        enable  <= 1'b1;
        for (int s = 0; s < `XC_FRAME_SAMPLES; s++) begin
            @(posedge sysclk);
            while (!smpclk) begin
                @(posedge sysclk);
            end
            frame_samples[s] = held;
            if (s < `XC_FRAME_SAMPLES - 1) begin
                held = next_lines(random_lines);
                line_in <= held;
            end
            if (s == pause_after) begin
                hold_paused();
            end
        end
    endtask

    // Checks one word of a burst against the model.
    task automatic check_word(input int pair, input xc_pkg::count_t expected);
        checks++;
        assert (word_strobe) else begin
            errors++;
            framing_errors++;
            $display("word_strobe missing for pair %0d at time %0t", pair, $time);
        end
        checks++;
        assert (word_index == xc_pkg::pair_idx_t'(pair)) else begin
            errors++;
            framing_errors++;
            $display("FAILED at time %0t: word_index expected %0d got %0d",
                     $time, pair, word_index);
        end
        checks++;
        assert (mux_out == expected) else begin
            errors++;
            $display("FAILED at time %0t: pair %0d expected %0d got %0d",
                     $time, pair, expected, mux_out);
        end
    endtask

    // Frame 1 is the all-high test, frames 2 to 4 are random, frame 5 has the pause.
    task automatic report_frame_test(input int frame);
        case (frame)
            1: finish_test("all lines high");
            4: finish_test("random frames");
            5: finish_test("pause inside a frame");
            default: ;
        endcase
    endtask

    // Counts smpclk pulses to find frame ends.
    // The ten words must follow on the next ten cycles, and word_strobe
    // stays low at every other cycle.
    initial begin : compare_words
        int pulses;
        int word_pos;
        xc_pkg::count_t want [`XC_NUM_PAIRS];
        pulses   = 0;
        word_pos = -1;
        forever begin
            @(posedge sysclk);
            if (rst_n) begin
                if (word_pos < 0) begin
                    checks++;
                    assert (!word_strobe) else begin
                        errors++;
                        framing_errors++;
                        $display("word_strobe high outside a readout burst at time %0t", $time);
                    end
                end else begin
                    if (word_pos == 0) begin
                        ref_pair_counts(frame_samples, want);
                    end
                    check_word(word_pos, want[word_pos]);
                    word_pos++;
                    if (word_pos == `XC_NUM_PAIRS) begin
                        word_pos = -1;
                        frames_checked++;
                        report_frame_test(frames_checked);
                    end
                end
                if (smpclk) begin
                    pulses++;
                    if (pulses == `XC_FRAME_SAMPLES) begin
                        pulses   = 0;
                        word_pos = 0;
                    end
                end
            end
        end
    end

    initial begin : main_sequence
        rst_n   = 1'b0;
        enable  = 1'b0;
        line_in = '0;
        void'($urandom(32'he840d8f2));

        // Reset state, then a few idle cycles with enable still low.
        repeat (RESET_CYCLES) begin
            @(posedge sysclk);
            check_idle_outputs();
        end
        rst_n <= 1'b1;
        repeat (IDLE_CYCLES) begin
            @(posedge sysclk);
            check_idle_outputs();
        end
        finish_test("reset state");

        // Frames run back to back so the sample pacing never breaks.
        run_frame(1'b0, -1);
        repeat (3) begin
            run_frame(1'b1, -1);
        end
        run_frame(1'b1, PAUSE_AFTER);
        wait (frames_checked == TOTAL_FRAMES);
        enable <= 1'b0;

        $display("Test word framing: %0d bursts, %0d framing errors",
                 frames_checked, framing_errors);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* xc_core.f */
+incdir+design
+incdir+verification
design/xc_pkg.sv
design/xc_sampler.sv
design/xc_pair_counter.sv
design/xc_readout.sv
design/xc_core.sv
verification/xc_tb.sv
